//--- hw/rl_filter_defs.svh
/*
 * Pair filter configuration
 * Lane count, distance pipeline depth, buffer sizing and cutoff
 */
`ifndef RL_FILTER_DEFS_SVH
`define RL_FILTER_DEFS_SVH

// Filter lanes feeding one force pipeline, 1 to 4
`define RL_NUM_LANES 2

// Register stages in r2_compute
`define RL_R2_LATENCY 3

// Entries per lane buffer, power of two only
`define RL_BUF_DEPTH 16

// 12.0 squared is 144.0, shifted up by 16 fraction bits
`define RL_CUTOFF2 36'h000900000

// Free slots at or below which the generator is stalled
// Pipeline plus filter stage hold 4 pairs
// One more pair may arrive after the stall is seen
// One spare slot for the generator reaction
`define RL_BP_THRESHOLD 6

`endif

//--- hw/rl_filter_pkg.sv
/*
 * Pair filter types
 * Fixed-point coordinates, deltas, squared distance, particle IDs
 * and the record kept in each lane buffer
 */
`default_nettype none

package rl_filter_pkg;

	// Coordinate, signed with 8 fraction bits
	typedef logic signed [15:0] coord_t;

	// Neighbor minus reference, one extra bit for the carry
	typedef logic signed [16:0] delta_t;

	// Sum of three squares, 16 fraction bits
	typedef logic [35:0] r2_t;

	typedef logic [11:0] pid_t;

	// IDs travelling alongside the distance pipeline
	typedef struct packed {
		pid_t ref_id;
		pid_t nbr_id;
	} id_pair_t;

	typedef struct packed {
		delta_t dz;
		delta_t dy;
		delta_t dx;
	} delta3_t;

	// Buffer record, MSB first
	typedef struct packed {
		pid_t   ref_id;
		pid_t   nbr_id;
		r2_t    r2;
		delta_t dz;
		delta_t dy;
		delta_t dx;
	} pair_rec_t;

endpackage

`default_nettype wire

//--- hw/delay_line.sv
/*
 * Delay line
 * Fixed number of register stages for an arbitrary payload type
 */
`default_nettype none
`timescale 1ns/1ns

module delay_line
#(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 1
)
(
	input  wire      clk,
	input  wire      rst,
	input  payload_t in,
	output payload_t out
);

	// Stage 0 is nearest the input
	payload_t stages [DEPTH];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < DEPTH; i++)
				stages[i] <= '0;
		end
		else
		begin
			stages[0] <= in;
			// Shift toward the output
			for (int i = 1; i < DEPTH; i++)
				stages[i] <= stages[i-1];
		end
	end

	assign out = stages[DEPTH-1];

endmodule

`default_nettype wire

//--- hw/r2_compute.sv
/*
 * Squared distance pipeline
 * Differences, squares and sum in three register stages
 * Deltas are delayed to come out with their r2
 */
`default_nettype none
`timescale 1ns/1ns
`include "rl_filter_defs.svh"

module r2_compute
	import rl_filter_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  wire         enable,
	input  wire coord_t ref_x,
	input  wire coord_t ref_y,
	input  wire coord_t ref_z,
	input  wire coord_t nbr_x,
	input  wire coord_t nbr_y,
	input  wire coord_t nbr_z,
	output logic        r2_valid,
	output r2_t         r2,
	output delta3_t     delta
);

	// Square of a 17 bit signed value fits in 34 bits unsigned
	delta3_t     d1;
	logic [33:0] sq_x, sq_y, sq_z;
	logic [2:0]  vld;
	r2_t         r2_sum;

	////////////////////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////////////////////

	// Stage 1, neighbor minus reference
	always_ff @(posedge clk)
	begin
		d1.dx <= delta_t'(nbr_x) - delta_t'(ref_x);
		d1.dy <= delta_t'(nbr_y) - delta_t'(ref_y);
		d1.dz <= delta_t'(nbr_z) - delta_t'(ref_z);
	end

	// Stage 2, squares
	always_ff @(posedge clk)
	begin
		sq_x <= d1.dx * d1.dx;
		sq_y <= d1.dy * d1.dy;
		sq_z <= d1.dz * d1.dz;
	end

	// Stage 3, sum with 16 fraction bits
	always_ff @(posedge clk)
	begin
		r2_sum <= r2_t'(sq_x) + r2_t'(sq_y) + r2_t'(sq_z);
	end

	// Deltas leave stage 1, so two more stages to line up
	delay_line #(
		.payload_t(delta3_t),
		.DEPTH(`RL_R2_LATENCY - 1)
	) i_delta_delay (
		.clk(clk),
		.rst(rst),
		.in(d1),
		.out(delta)
	);

	// Valid strobe follows the data
	always_ff @(posedge clk)
	begin
		if (rst)
			vld <= '0;
		else
			vld <= {vld[1:0], enable};
	end

	assign r2_valid = vld[2];
	assign r2       = r2_sum;

endmodule

`default_nettype wire

//--- hw/pair_fifo.sv
/*
 * Lane pair buffer
 * Show-ahead synchronous FIFO of pair records with fill count
 * Simultaneous write and read are both taken
 */
`default_nettype none
`timescale 1ns/1ns
`include "rl_filter_defs.svh"

module pair_fifo
	import rl_filter_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire            wr,
	input  wire pair_rec_t wr_data,
	input  wire            rd,
	output pair_rec_t      rd_data,
	output logic           empty,
	output logic           full,
	output logic [$clog2(`RL_BUF_DEPTH):0] used
);

	localparam int AW = $clog2(`RL_BUF_DEPTH);

	pair_rec_t     mem [`RL_BUF_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   cnt;
	logic          do_wr;
	logic          do_rd;

	// Overflow and underflow are dropped here
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	// Storage
	always_ff @(posedge clk)
	begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end
		else
		begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			// Count unchanged when both happen
			if (do_wr && !do_rd)
				cnt <= cnt + 1'b1;
			else if (do_rd && !do_wr)
				cnt <= cnt - 1'b1;
		end
	end

	// Front entry always on the output
	assign rd_data = mem[rd_ptr];
	assign empty   = (cnt == '0);
	assign full    = (cnt == (AW+1)'(`RL_BUF_DEPTH));
	assign used    = cnt;

endmodule

`default_nettype wire

//--- hw/filter_logic.sv
/*
 * Filter lane
 * Squared distance, cutoff test and buffering of kept pairs
 * Stalls its generator before the buffer can overflow
 */
`default_nettype none
`timescale 1ns/1ns
`include "rl_filter_defs.svh"

module filter_logic
	import rl_filter_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  wire         in_valid,
	input  wire pid_t   ref_id,
	input  wire pid_t   nbr_id,
	input  wire coord_t ref_x,
	input  wire coord_t ref_y,
	input  wire coord_t ref_z,
	input  wire coord_t nbr_x,
	input  wire coord_t nbr_y,
	input  wire coord_t nbr_z,
	input  wire         sel,
	output pair_rec_t   head,
	output logic        pair_available,
	output logic        back_pressure
);

	localparam int AW = $clog2(`RL_BUF_DEPTH);

	logic        r2_valid;
	r2_t         r2;
	delta3_t     delta;
	id_pair_t    ids_in;
	id_pair_t    ids_d;
	logic        keep;
	logic        buf_wr;
	pair_rec_t   buf_rec;
	logic        buf_empty;
	logic        buf_full;
	logic [AW:0] buf_used;
	logic [AW:0] buf_free;

	r2_compute i_r2_compute (
		.clk(clk),
		.rst(rst),
		.enable(in_valid),
		.ref_x(ref_x),
		.ref_y(ref_y),
		.ref_z(ref_z),
		.nbr_x(nbr_x),
		.nbr_y(nbr_y),
		.nbr_z(nbr_z),
		.r2_valid(r2_valid),
		.r2(r2),
		.delta(delta)
	);

	// IDs ride along with the distance pipeline
	assign ids_in = '{ref_id: ref_id, nbr_id: nbr_id};

	delay_line #(
		.payload_t(id_pair_t),
		.DEPTH(`RL_R2_LATENCY)
	) i_id_delay (
		.clk(clk),
		.rst(rst),
		.in(ids_in),
		.out(ids_d)
	);

	////////////////////////////////////////////////////////////////////////////
	// Cutoff filter
	////////////////////////////////////////////////////////////////////////////

	// Zero distance means a particle paired with itself
	assign keep = r2_valid && (r2 != '0) && (r2 <= `RL_CUTOFF2);

	always_ff @(posedge clk)
	begin
		if (rst)
			buf_wr <= 1'b0;
		else
			buf_wr <= keep;
	end

	// Record layout matches the force pipeline input
	always_ff @(posedge clk)
	begin
		buf_rec <= '{ref_id: ids_d.ref_id, nbr_id: ids_d.nbr_id, r2: r2,
			dz: delta.dz, dy: delta.dy, dx: delta.dx};
	end

	pair_fifo i_pair_fifo (
		.clk(clk),
		.rst(rst),
		.wr(buf_wr),
		.wr_data(buf_rec),
		.rd(sel),
		.rd_data(head),
		.empty(buf_empty),
		.full(buf_full),
		.used(buf_used)
	);

	assign pair_available = !buf_empty;

	// Stall while the in-flight pairs might not fit
	assign buf_free      = (AW+1)'(`RL_BUF_DEPTH) - buf_used;
	assign back_pressure = (buf_free <= (AW+1)'(`RL_BP_THRESHOLD));

endmodule

`default_nettype wire

//--- hw/filter_arbiter.sv
/*
 * Lane arbiter
 * Round-robin pop of non-empty lane buffers
 * One registered pair per cycle toward the force pipeline
 */
`default_nettype none
`timescale 1ns/1ns
`include "rl_filter_defs.svh"

module filter_arbiter
	import rl_filter_pkg::*;
(
	input  wire            clk,
	input  wire            rst,
	input  wire            pair_available [`RL_NUM_LANES],
	input  wire pair_rec_t head [`RL_NUM_LANES],
	output logic           sel [`RL_NUM_LANES],
	output logic           out_valid,
	output pid_t           out_ref_id,
	output pid_t           out_nbr_id,
	output r2_t            out_r2,
	output delta_t         out_dx,
	output delta_t         out_dy,
	output delta_t         out_dz
);

	localparam int N  = `RL_NUM_LANES;
	localparam int LW = (N > 1) ? $clog2(N) : 1;

	// Lane tried first this cycle
	logic [LW-1:0] ptr;
	logic [LW-1:0] grant;
	logic          found;

	// First available lane at or after the pointer
	always_comb
	begin
		int idx;
		found = 1'b0;
		grant = '0;
		for (int i = 0; i < N; i++)
		begin
			idx = (int'(ptr) + i) % N;
			if (!found && pair_available[idx])
			begin
				found = 1'b1;
				grant = LW'(idx);
			end
		end
	end

	// Pop pulse, one lane at most
	always_comb
	begin
		for (int i = 0; i < N; i++)
			sel[i] = found && (grant == LW'(i));
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			ptr       <= '0;
		end
		else
		begin
			out_valid <= found;
			// Next search starts past the served lane
			if (found)
				ptr <= LW'((int'(grant) + 1) % N);
		end
	end

	// Output payload, qualified by out_valid
	always_ff @(posedge clk)
	begin
		out_ref_id <= head[grant].ref_id;
		out_nbr_id <= head[grant].nbr_id;
		out_r2     <= head[grant].r2;
		out_dx     <= head[grant].dx;
		out_dy     <= head[grant].dy;
		out_dz     <= head[grant].dz;
	end

endmodule

`default_nettype wire

//--- hw/filter_bank.sv
/*
 * Filter bank
 * Filter lanes sharing one force pipeline through a round-robin arbiter
 */
`default_nettype none
`timescale 1ns/1ns
`include "rl_filter_defs.svh"

module filter_bank
	import rl_filter_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	// Generator side, one entry per lane
	input  wire         in_valid [`RL_NUM_LANES],
	input  wire pid_t   ref_id [`RL_NUM_LANES],
	input  wire pid_t   nbr_id [`RL_NUM_LANES],
	input  wire coord_t ref_x [`RL_NUM_LANES],
	input  wire coord_t ref_y [`RL_NUM_LANES],
	input  wire coord_t ref_z [`RL_NUM_LANES],
	input  wire coord_t nbr_x [`RL_NUM_LANES],
	input  wire coord_t nbr_y [`RL_NUM_LANES],
	input  wire coord_t nbr_z [`RL_NUM_LANES],
	output logic        back_pressure [`RL_NUM_LANES],
	// Force pipeline side
	output logic        out_valid,
	output pid_t        out_ref_id,
	output pid_t        out_nbr_id,
	output r2_t         out_r2,
	output delta_t      out_dx,
	output delta_t      out_dy,
	output delta_t      out_dz
);

	logic      pair_available [`RL_NUM_LANES];
	pair_rec_t head [`RL_NUM_LANES];
	logic      sel [`RL_NUM_LANES];

	////////////////////////////////////////////////////////////////////////////
	// Lanes
	////////////////////////////////////////////////////////////////////////////
	for (genvar g = 0; g < `RL_NUM_LANES; g++)
	begin : g_lane
		filter_logic i_filter_logic (
			.clk(clk),
			.rst(rst),
			.in_valid(in_valid[g]),
			.ref_id(ref_id[g]),
			.nbr_id(nbr_id[g]),
			.ref_x(ref_x[g]),
			.ref_y(ref_y[g]),
			.ref_z(ref_z[g]),
			.nbr_x(nbr_x[g]),
			.nbr_y(nbr_y[g]),
			.nbr_z(nbr_z[g]),
			.sel(sel[g]),
			.head(head[g]),
			.pair_available(pair_available[g]),
			.back_pressure(back_pressure[g])
		);
	end

	filter_arbiter i_filter_arbiter (
		.clk(clk),
		.rst(rst),
		.pair_available(pair_available),
		.head(head),
		.sel(sel),
		.out_valid(out_valid),
		.out_ref_id(out_ref_id),
		.out_nbr_id(out_nbr_id),
		.out_r2(out_r2),
		.out_dx(out_dx),
		.out_dy(out_dy),
		.out_dz(out_dz)
	);

endmodule

`default_nettype wire

//--- verif/filter_bank_props.sv
/*
 * Filter bank properties
 * Lane buffer overflow, single pop per cycle, no pop from an empty lane
 */
`default_nettype none
`timescale 1ns/1ns
`include "rl_filter_defs.svh"

module filter_bank_props
#(
	parameter int N = 1
)
(
	input wire clk,
	input wire rst,
	input wire buf_wr,
	input wire buf_full,
	input wire sel [N],
	input wire avail [N]
);

	// Number of pop pulses this cycle
	int sel_cnt;

	always_comb
	begin
		sel_cnt = 0;
		for (int i = 0; i < N; i++)
			sel_cnt += int'(sel[i]);
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		!(buf_wr && buf_full))
		else $error("write into a full lane buffer");

	a_one_pop: assert property (@(posedge clk) disable iff (rst) sel_cnt <= 1)
		else $error("more than one lane popped in a cycle");

	// Pop only from a lane holding a pair
	for (genvar g = 0; g < N; g++)
	begin : g_pop
		a_pop_avail: assert property (@(posedge clk) disable iff (rst)
			sel[g] |-> avail[g])
			else $error("pop from an empty lane buffer");
	end

endmodule

bind filter_logic filter_bank_props #(.N(1)) i_lane_props (
	.clk(clk),
	.rst(rst),
	.buf_wr(buf_wr),
	.buf_full(buf_full),
	.sel('{sel}),
	.avail('{pair_available})
);

bind filter_arbiter filter_bank_props #(.N(`RL_NUM_LANES)) i_arb_props (
	.clk(clk),
	.rst(rst),
	.buf_wr(1'b0),
	.buf_full(1'b0),
	.sel(sel),
	.avail(pair_available)
);

`default_nettype wire

//--- verif/filter_bank_tb.sv
/*
 * Filter bank testbench
 * Directed tests against a per-lane reference model of the cutoff filter
 */
`default_nettype none
`timescale 1ns/1ns
`include "rl_filter_defs.svh"

module filter_bank_tb
	import rl_filter_pkg::*;
;

	localparam int N = `RL_NUM_LANES;
	// About 260 pairs plus drain of six tests, with a wide margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic   clk;
	logic   rst;
	logic   in_valid [N];
	pid_t   ref_id [N];
	pid_t   nbr_id [N];
	coord_t ref_x [N];
	coord_t ref_y [N];
	coord_t ref_z [N];
	coord_t nbr_x [N];
	coord_t nbr_y [N];
	coord_t nbr_z [N];
	logic   back_pressure [N];
	logic   out_valid;
	pid_t   out_ref_id;
	pid_t   out_nbr_id;
	r2_t    out_r2;
	delta_t out_dx;
	delta_t out_dy;
	delta_t out_dz;

	// Expected records per lane, oldest first
	pair_rec_t exp_q [N][$];
	int        lane_log [$];
	int        cycles;
	int        out_total;
	// Pairs the model has kept so far
	int        exp_total;
	int        mismatch_cnt;
	int        other_cnt;
	string     cur_test;

	filter_bank i_filter_bank (
		.clk(clk), .rst(rst), .in_valid(in_valid),
		.ref_id(ref_id), .nbr_id(nbr_id),
		.ref_x(ref_x), .ref_y(ref_y), .ref_z(ref_z),
		.nbr_x(nbr_x), .nbr_y(nbr_y), .nbr_z(nbr_z),
		.back_pressure(back_pressure), .out_valid(out_valid),
		.out_ref_id(out_ref_id), .out_nbr_id(out_nbr_id), .out_r2(out_r2),
		.out_dx(out_dx), .out_dy(out_dy), .out_dz(out_dz)
	);

	always #20 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_rec(input string test, input pair_rec_t exp, input pair_rec_t act);
		if (exp !== act)
		begin
			$display("MISMATCH %s expected %h actual %h", test, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic check_count(input string test, input int exp, input int act);
		if (exp != act)
		begin
			$display("MISMATCH %s expected %0d actual %0d", test, exp, act);
			mismatch_cnt++;
		end
	endtask

	task automatic report_error(input string what);
		$display("ERROR %s: %s", cur_test, what);
		other_cnt++;
	endtask

	// Cycle counter and run limit
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Output monitor, lane is taken from the ID range
	always @(negedge clk)
	begin
		pair_rec_t act;
		int        lane;
		if (!rst && out_valid)
		begin
			act = '{ref_id: out_ref_id, nbr_id: out_nbr_id, r2: out_r2,
				dz: out_dz, dy: out_dy, dx: out_dx};
			lane = int'(out_ref_id[11:10]);
			out_total++;
			lane_log.push_back(lane);
			if (lane >= N || exp_q[lane].size() == 0)
				report_error("output pair that no lane should have produced");
			else
				check_rec(cur_test, exp_q[lane].pop_front(), act);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////////////////////////////////////////

	task automatic idle_lanes();
		for (int i = 0; i < N; i++)
			in_valid[i] = 1'b0;
	endtask

	// Present one pair on a lane and predict the record
	task automatic drive_pair(input int lane, input pid_t r, input pid_t n,
		input coord_t rx, input coord_t ry, input coord_t rz,
		input coord_t nx, input coord_t ny, input coord_t nz);
		longint    lx;
		longint    ly;
		longint    lz;
		longint    sum;
		pair_rec_t rec;
		lx = longint'(nx) - longint'(rx);
		ly = longint'(ny) - longint'(ry);
		lz = longint'(nz) - longint'(rz);
		sum = lx * lx + ly * ly + lz * lz;
		in_valid[lane] = 1'b1;
		ref_id[lane] = r;
		nbr_id[lane] = n;
		ref_x[lane] = rx;
		ref_y[lane] = ry;
		ref_z[lane] = rz;
		nbr_x[lane] = nx;
		nbr_y[lane] = ny;
		nbr_z[lane] = nz;
		rec = '{ref_id: r, nbr_id: n, r2: r2_t'(sum),
			dz: delta_t'(lz), dy: delta_t'(ly), dx: delta_t'(lx)};
		// Kept only strictly above zero and up to the cutoff
		if (sum > 0 && sum <= longint'(`RL_CUTOFF2))
		begin
			exp_q[lane].push_back(rec);
			exp_total++;
		end
	endtask

	function automatic coord_t rand_coord();
		return coord_t'($urandom_range(4095)) - 16'sd2048;
	endfunction

	function automatic pid_t lane_id(input int lane, input int k);
		return pid_t'((lane << 10) | (k & 32'h3ff));
	endfunction

	// Random pair on a lane, near when requested
	// Far pairs reach beyond the cutoff on x
	task automatic drive_random(input int lane, input int k, input bit near);
		coord_t rx;
		coord_t ry;
		coord_t rz;
		rx = rand_coord();
		ry = rand_coord();
		rz = rand_coord();
		if (near)
			drive_pair(lane, lane_id(lane, k), pid_t'(k), rx, ry, rz,
				rx + coord_t'($urandom_range(1, 1023)), ry, rz);
		else
			drive_pair(lane, lane_id(lane, k), pid_t'(k), rx, ry, rz,
				rx + coord_t'($urandom_range(8191)) - 16'sd4096,
				ry + coord_t'($urandom_range(2047)) - 16'sd1024, rz);
	endtask

	function automatic bit queues_empty();
		for (int i = 0; i < N; i++)
			if (exp_q[i].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	// Wait for every expected pair, then watch for strays
	task automatic wait_drain();
		@(negedge clk);
		idle_lanes();
		while (!queues_empty())
			@(negedge clk);
		repeat (8) @(negedge clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_latency();
		int in_edge;
		cur_test = "latency";
		@(negedge clk);
		drive_pair(0, lane_id(0, 1), 12'd7, 16'sd256, -16'sd512, 16'sd0,
			16'sd1280, 16'sd0, 16'sd768);
		// Rising edge that opens the cycle carrying the pair
		in_edge = cycles;
		@(negedge clk);
		idle_lanes();
		while (!out_valid)
			@(negedge clk);
		check_count("latency cycles", 6, cycles - in_edge);
		wait_drain();
	endtask

	task automatic test_cutoff();
		int start;
		cur_test = "cutoff";
		start = out_total;
		@(negedge clk);
		// Exactly 12.0 apart
		drive_pair(0, lane_id(0, 2), 12'd1, 16'sd0, 16'sd0, 16'sd0,
			16'sd3072, 16'sd0, 16'sd0);
		@(negedge clk);
		// One r2 LSB past the cutoff
		drive_pair(0, lane_id(0, 3), 12'd2, 16'sd0, 16'sd0, 16'sd0,
			16'sd3072, 16'sd1, 16'sd0);
		@(negedge clk);
		// Same position
		drive_pair(0, lane_id(0, 4), 12'd3, 16'sd100, 16'sd100, 16'sd100,
			16'sd100, 16'sd100, 16'sd100);
		wait_drain();
		check_count("cutoff count", 1, out_total - start);
	endtask

	task automatic test_random();
		int start;
		int exp_start;
		cur_test = "random";
		start = out_total;
		exp_start = exp_total;
		for (int k = 0; k < 60; k++)
		begin
			@(negedge clk);
			idle_lanes();
			for (int l = 0; l < N; l++)
				if (!back_pressure[l])
					drive_random(l, k, 1'b0);
		end
		wait_drain();
		check_count("random count", exp_total - exp_start, out_total - start);
	endtask

	task automatic test_fairness();
		cur_test = "fairness";
		lane_log.delete();
		for (int k = 0; k < 6; k++)
		begin
			@(negedge clk);
			idle_lanes();
			for (int l = 0; l < N; l++)
				drive_random(l, 100 + k, 1'b1);
		end
		wait_drain();
		check_count("fairness count", 6 * N, lane_log.size());
		for (int i = 1; i < lane_log.size(); i++)
			if (lane_log[i] == lane_log[i-1])
				report_error("same lane served twice while both held pairs");
	endtask

	task automatic test_back_pressure();
		bit saw_bp;
		int start;
		int sent;
		cur_test = "back_pressure";
		saw_bp = 1'b0;
		start = out_total;
		sent = 0;
		for (int k = 0; k < 120; k++)
		begin
			@(negedge clk);
			idle_lanes();
			if (back_pressure[0])
				saw_bp = 1'b1;
			for (int l = 0; l < N; l++)
				if (!back_pressure[l])
				begin
					drive_random(l, 200 + k, 1'b1);
					sent++;
				end
		end
		wait_drain();
		check_count("back_pressure count", sent, out_total - start);
		if (!saw_bp)
			report_error("back_pressure never rose on a flooded lane");
		for (int l = 0; l < N; l++)
			if (back_pressure[l])
				report_error("back_pressure still high after the buffer drained");
	endtask

	task automatic test_reset();
		cur_test = "reset";
		for (int k = 0; k < 4; k++)
		begin
			@(negedge clk);
			idle_lanes();
			for (int l = 0; l < N; l++)
				drive_random(l, 400 + k, 1'b1);
		end
		@(negedge clk);
		idle_lanes();
		rst = 1'b1;
		repeat (2) @(negedge clk);
		rst = 1'b0;
		// Pairs in flight are discarded by reset
		for (int l = 0; l < N; l++)
			exp_q[l].delete();
		repeat (10)
		begin
			@(negedge clk);
			if (out_valid)
				report_error("out_valid high after reset");
			for (int l = 0; l < N; l++)
				if (back_pressure[l])
					report_error("back_pressure high after reset");
		end
		drive_pair(1, lane_id(1, 500), 12'd9, -16'sd300, 16'sd40, 16'sd0,
			16'sd300, 16'sd40, -16'sd100);
		wait_drain();
	endtask

	initial
	begin
		void'($urandom(32'hd95f_7a03));
		clk = 1'b0;
		rst = 1'b1;
		cycles = 0;
		out_total = 0;
		exp_total = 0;
		mismatch_cnt = 0;
		other_cnt = 0;
		cur_test = "reset_seq";
		for (int l = 0; l < N; l++)
		begin
			in_valid[l] = 1'b0;
			ref_id[l] = '0;
			nbr_id[l] = '0;
			ref_x[l] = '0;
			ref_y[l] = '0;
			ref_z[l] = '0;
			nbr_x[l] = '0;
			nbr_y[l] = '0;
			nbr_z[l] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_latency();
		test_cutoff();
		test_random();
		test_fairness();
		test_back_pressure();
		test_reset();
		$display("Errors: mismatches %0d, other %0d", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- filter_bank.f
+incdir+hw
hw/rl_filter_pkg.sv
hw/delay_line.sv
hw/r2_compute.sv
hw/pair_fifo.sv
hw/filter_logic.sv
hw/filter_arbiter.sv
hw/filter_bank.sv
verif/filter_bank_props.sv
verif/filter_bank_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the filter bank testbench with Verilator and run it
verilator --binary --timing --assert --top-module filter_bank_tb \
	-f filter_bank.f -o filter_bank_sim &&
./obj_dir/filter_bank_sim | tee /dev/stderr | grep -q "TEST PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
